// ==== rtl/dualIssuePkg.sv ====
package dualIssuePkg;

    // ALU operations seen by the execute stage
    typedef enum logic [3:0] {
        aluAdd   = 4'd0,
        aluSub   = 4'd1,
        aluSll   = 4'd2,
        aluSlt   = 4'd3,
        aluSltu  = 4'd4,
        aluXor   = 4'd5,
        aluSrl   = 4'd6,
        aluSra   = 4'd7,
        aluOr    = 4'd8,
        aluAnd   = 4'd9,
        aluPassB = 4'd10
    } aluOpT;

    typedef enum logic [1:0] {
        resAlu     = 2'd0,
        resMem     = 2'd1,
        resPcPlus4 = 2'd2
    } resultSrcT;

    typedef enum logic [1:0] {
        jumpNone = 2'd0,
        jumpJal  = 2'd1,
        jumpJalr = 2'd2
    } jumpT;

    // RV32I major opcodes handled by the decoder
    localparam logic [6:0] opOp     = 7'b0110011;
    localparam logic [6:0] opOpImm  = 7'b0010011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;

endpackage

// ==== rtl/controlDecoder.sv ====
module controlDecoder import dualIssuePkg::*; (
    input  logic [6:0] opcode,
    input  logic [2:0] funct3,
    input  logic       funct7b5,
    output logic       regWrite,
    output resultSrcT  resultSrc,
    output logic       memWrite,
    output jumpT       jump,
    output logic       branch,
    output aluOpT      aluControl,
    output logic       aluSrcA,
    output logic       aluSrcB,
    output logic [2:0] addressingControl,
    output logic [2:0] branchType
);

    always_comb begin
        // anything not listed below leaves a bubble
        regWrite          = 1'b0;
        resultSrc         = resAlu;
        memWrite          = 1'b0;
        jump              = jumpNone;
        branch            = 1'b0;
        aluControl        = aluAdd;
        aluSrcA           = 1'b0;
        aluSrcB           = 1'b0;
        addressingControl = 3'b000;
        branchType        = 3'b000;

        case (opcode)
            opOp, opOpImm: begin
                regWrite = 1'b1;
                aluSrcB  = (opcode == opOpImm);
                case (funct3)
                    // addi has no subtract form, bit 30 belongs to its immediate
                    3'b000: aluControl = (funct7b5 && opcode == opOp) ? aluSub : aluAdd;
                    3'b001: aluControl = aluSll;
                    3'b010: aluControl = aluSlt;
                    3'b011: aluControl = aluSltu;
                    3'b100: aluControl = aluXor;
                    3'b101: aluControl = funct7b5 ? aluSra : aluSrl;
                    3'b110: aluControl = aluOr;
                    default: aluControl = aluAnd;
                endcase
            end
            opLoad: begin
                regWrite          = 1'b1;
                resultSrc         = resMem;
                aluSrcB           = 1'b1;
                addressingControl = funct3;
            end
            opStore: begin
                memWrite          = 1'b1;
                aluSrcB           = 1'b1;
                addressingControl = funct3;
            end
            opBranch: begin
                branch     = 1'b1;
                aluControl = aluSub;
                branchType = funct3;
            end
            opJal: begin
                // target is computed as pc + imm in the ALU
                regWrite  = 1'b1;
                resultSrc = resPcPlus4;
                jump      = jumpJal;
                aluSrcA   = 1'b1;
                aluSrcB   = 1'b1;
            end
            opJalr: begin
                regWrite  = 1'b1;
                resultSrc = resPcPlus4;
                jump      = jumpJalr;
                aluSrcB   = 1'b1;
            end
            opLui: begin
                regWrite   = 1'b1;
                aluSrcB    = 1'b1;
                aluControl = aluPassB;
            end
            opAuipc: begin
                regWrite = 1'b1;
                aluSrcA  = 1'b1;
                aluSrcB  = 1'b1;
            end
            default: begin
                regWrite = 1'b0;
            end
        endcase
    end

endmodule

// ==== rtl/immediateGen.sv ====
module immediateGen import dualIssuePkg::*; (
    input  logic [31:0] instr,
    output logic [31:0] immExt
);

    always_comb begin
        case (instr[6:0])
            // I format
            opLoad, opOpImm, opJalr: begin
                immExt = {{20{instr[31]}}, instr[31:20]};
            end
            opStore: begin
                immExt = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            // B and J offsets are in halfwords, so bit 0 is always zero
            opBranch: begin
                immExt = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                          instr[11:8], 1'b0};
            end
            opJal: begin
                immExt = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                          instr[30:21], 1'b0};
            end
            opLui, opAuipc: begin
                immExt = {instr[31:12], 12'b0};
            end
            default: begin
                immExt = 32'b0;
            end
        endcase
    end

endmodule

// ==== rtl/laneDecoder.sv ====
module laneDecoder import dualIssuePkg::*; (
    input  logic [31:0] instr,
    input  logic [31:0] pc,
    output logic [4:0]  rs1,
    output logic [4:0]  rs2,
    output logic [4:0]  rd,
    output logic        regWrite,
    output resultSrcT   resultSrc,
    output logic        memWrite,
    output jumpT        jump,
    output logic        branch,
    output aluOpT       aluControl,
    output logic        aluSrcA,
    output logic        aluSrcB,
    output logic [2:0]  addressingControl,
    output logic [2:0]  branchType,
    output logic [31:0] immExt,
    output logic [31:0] pcPlus4,
    output logic [31:0] pcPlus8
);

    // fields are sliced the same way for every format
    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];

    assign pcPlus4 = pc + 32'd4;
    assign pcPlus8 = pc + 32'd8;

    controlDecoder ctrlDec (
        .opcode   (instr[6:0]),
        .funct3   (instr[14:12]),
        .funct7b5 (instr[30]),
        .*
    );

    immediateGen immGen (.*);

endmodule

// ==== rtl/registerFile.sv ====
module registerFile (
    input  logic        clk,
    input  logic        rst1,
    input  logic [4:0]  ra1, ra2, ra4, ra5,
    output logic [31:0] rd1, rd2, rd4, rd5,
    input  logic        we1, we2,
    input  logic [4:0]  wa1, wa2,
    input  logic [31:0] wd1, wd2
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst1) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'b0;
            end
        end else begin
            if (we1) begin
                regs[wa1] <= wd1;
            end
            // second writeback port is younger and wins on a shared address
            if (we2) begin
                regs[wa2] <= wd2;
            end
        end
    end

    // no bypass, a write lands at the edge and reads see the old value until then
    assign rd1 = (ra1 == 5'd0) ? 32'b0 : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? 32'b0 : regs[ra2];
    assign rd4 = (ra4 == 5'd0) ? 32'b0 : regs[ra4];
    assign rd5 = (ra5 == 5'd0) ? 32'b0 : regs[ra5];

endmodule

// ==== rtl/issueControl.sv ====
module issueControl (
    input  logic       valid1,
    input  logic       valid2,
    input  logic       stall,
    input  logic       flush,
    input  logic       regWrite1,
    input  logic [4:0] rd1,
    input  logic [4:0] rs1Lane2,
    input  logic [4:0] rs2Lane2,
    output logic       en1,
    output logic       en2,
    output logic       clearLane1,
    output logic       clearLane2,
    output logic       splitPair
);

    logic dependency;

    // lane 2 cannot issue with lane 1 when it reads lane 1's result
    assign dependency = valid1 && valid2 && regWrite1 && (rd1 != 5'd0)
                        && ((rd1 == rs1Lane2) || (rd1 == rs2Lane2));

    always_comb begin
        en1        = 1'b1;
        en2        = 1'b1;
        clearLane1 = !valid1;
        clearLane2 = !valid2 || dependency;
        splitPair  = dependency;

        if (flush) begin
            en1        = 1'b0;
            en2        = 1'b0;
            clearLane1 = 1'b1;
            clearLane2 = 1'b1;
            splitPair  = 1'b0;
        end else if (stall) begin
            en1        = 1'b0;
            en2        = 1'b0;
            clearLane1 = 1'b0;
            clearLane2 = 1'b0;
            splitPair  = 1'b0;
        end
    end

endmodule

// ==== rtl/decodeToExecuteRegister.sv ====
module decodeToExecuteRegister import dualIssuePkg::*; (
    input  logic        clk,
    input  logic        rst1,
    input  logic        clearLane1, clearLane2,
    input  logic        en1, en2,

    input  logic        regWriteD1, regWriteD2,
    input  resultSrcT   resultSrcD1, resultSrcD2,
    input  logic        memWriteD1, memWriteD2,
    input  jumpT        jumpD1, jumpD2,
    input  logic        branchD1, branchD2,
    input  aluOpT       aluControlD1, aluControlD2,
    input  logic        aluSrcAD1, aluSrcAD2,
    input  logic        aluSrcBD1, aluSrcBD2,
    input  logic [2:0]  addressingControlD1, addressingControlD2,
    input  logic [2:0]  branchTypeD1, branchTypeD2,

    // lane 1 reads through ports 1 and 2, lane 2 through ports 4 and 5
    input  logic [31:0] rd1D, rd2D, rd4D, rd5D,
    input  logic [4:0]  rs1D, rs2D, rs4D, rs5D,
    input  logic [4:0]  rdD1, rdD2,
    input  logic [31:0] pcD1, pcD2,
    input  logic [31:0] immExtD1, immExtD2,
    input  logic [31:0] pcPlus4D1, pcPlus4D2,
    input  logic [31:0] pcPlus8D1, pcPlus8D2,

    output logic        regWriteE1, regWriteE2,
    output resultSrcT   resultSrcE1, resultSrcE2,
    output logic        memWriteE1, memWriteE2,
    output jumpT        jumpE1, jumpE2,
    output logic        branchE1, branchE2,
    output aluOpT       aluControlE1, aluControlE2,
    output logic        aluSrcAE1, aluSrcAE2,
    output logic        aluSrcBE1, aluSrcBE2,
    output logic [2:0]  addressingControlE1, addressingControlE2,
    output logic [2:0]  branchTypeE1, branchTypeE2,

    output logic [31:0] rd1E, rd2E, rd4E, rd5E,
    output logic [4:0]  rs1E, rs2E, rs4E, rs5E,
    output logic [4:0]  rdE1, rdE2,
    output logic [31:0] pcE1, pcE2,
    output logic [31:0] immExtE1, immExtE2,
    output logic [31:0] pcPlus4E1, pcPlus4E2,
    output logic [31:0] pcPlus8E1, pcPlus8E2
);

    always_ff @(posedge clk) begin
        // a cleared lane becomes a bubble with every enable inactive
        if (rst1 || clearLane1) begin
            regWriteE1          <= 1'b0;
            resultSrcE1         <= resAlu;
            memWriteE1          <= 1'b0;
            jumpE1              <= jumpNone;
            branchE1            <= 1'b0;
            aluControlE1        <= aluAdd;
            aluSrcAE1           <= 1'b0;
            aluSrcBE1           <= 1'b0;
            addressingControlE1 <= 3'b0;
            branchTypeE1        <= 3'b0;
            rd1E                <= 32'b0;
            rd2E                <= 32'b0;
            rs1E                <= 5'b0;
            rs2E                <= 5'b0;
            rdE1                <= 5'b0;
            pcE1                <= 32'b0;
            immExtE1            <= 32'b0;
            pcPlus4E1           <= 32'b0;
            pcPlus8E1           <= 32'b0;
        end else if (en1) begin
            regWriteE1          <= regWriteD1;
            resultSrcE1         <= resultSrcD1;
            memWriteE1          <= memWriteD1;
            jumpE1              <= jumpD1;
            branchE1            <= branchD1;
            aluControlE1        <= aluControlD1;
            aluSrcAE1           <= aluSrcAD1;
            aluSrcBE1           <= aluSrcBD1;
            addressingControlE1 <= addressingControlD1;
            branchTypeE1        <= branchTypeD1;
            rd1E                <= rd1D;
            rd2E                <= rd2D;
            rs1E                <= rs1D;
            rs2E                <= rs2D;
            rdE1                <= rdD1;
            pcE1                <= pcD1;
            immExtE1            <= immExtD1;
            pcPlus4E1           <= pcPlus4D1;
            pcPlus8E1           <= pcPlus8D1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst1 || clearLane2) begin
            regWriteE2          <= 1'b0;
            resultSrcE2         <= resAlu;
            memWriteE2          <= 1'b0;
            jumpE2              <= jumpNone;
            branchE2            <= 1'b0;
            aluControlE2        <= aluAdd;
            aluSrcAE2           <= 1'b0;
            aluSrcBE2           <= 1'b0;
            addressingControlE2 <= 3'b0;
            branchTypeE2        <= 3'b0;
            rd4E                <= 32'b0;
            rd5E                <= 32'b0;
            rs4E                <= 5'b0;
            rs5E                <= 5'b0;
            rdE2                <= 5'b0;
            pcE2                <= 32'b0;
            immExtE2            <= 32'b0;
            pcPlus4E2           <= 32'b0;
            pcPlus8E2           <= 32'b0;
        end else if (en2) begin
            regWriteE2          <= regWriteD2;
            resultSrcE2         <= resultSrcD2;
            memWriteE2          <= memWriteD2;
            jumpE2              <= jumpD2;
            branchE2            <= branchD2;
            aluControlE2        <= aluControlD2;
            aluSrcAE2           <= aluSrcAD2;
            aluSrcBE2           <= aluSrcBD2;
            addressingControlE2 <= addressingControlD2;
            branchTypeE2        <= branchTypeD2;
            rd4E                <= rd4D;
            rd5E                <= rd5D;
            rs4E                <= rs4D;
            rs5E                <= rs5D;
            rdE2                <= rdD2;
            pcE2                <= pcD2;
            immExtE2            <= immExtD2;
            pcPlus4E2           <= pcPlus4D2;
            pcPlus8E2           <= pcPlus8D2;
        end
    end

endmodule

// ==== rtl/decodeStage.sv ====
module decodeStage import dualIssuePkg::*; (
    input  logic        clk,
    input  logic        rst1,
    input  logic [31:0] instr1, pc1,
    input  logic        valid1,
    input  logic [31:0] instr2, pc2,
    input  logic        valid2,
    input  logic        stall, flush,
    input  logic        wbEn1, wbEn2,
    input  logic [4:0]  wbAddr1, wbAddr2,
    input  logic [31:0] wbData1, wbData2,

    output logic        regWriteE1, regWriteE2,
    output resultSrcT   resultSrcE1, resultSrcE2,
    output logic        memWriteE1, memWriteE2,
    output jumpT        jumpE1, jumpE2,
    output logic        branchE1, branchE2,
    output aluOpT       aluControlE1, aluControlE2,
    output logic        aluSrcAE1, aluSrcAE2,
    output logic        aluSrcBE1, aluSrcBE2,
    output logic [2:0]  addressingControlE1, addressingControlE2,
    output logic [2:0]  branchTypeE1, branchTypeE2,
    output logic [31:0] rd1E, rd2E, rd4E, rd5E,
    output logic [4:0]  rs1E, rs2E, rs4E, rs5E,
    output logic [4:0]  rdE1, rdE2,
    output logic [31:0] pcE1, pcE2,
    output logic [31:0] immExtE1, immExtE2,
    output logic [31:0] pcPlus4E1, pcPlus4E2,
    output logic [31:0] pcPlus8E1, pcPlus8E2,
    output logic        splitPair
);

    // decode-side values, named after the pipeline register inputs
    logic        regWriteD1, regWriteD2;
    resultSrcT   resultSrcD1, resultSrcD2;
    logic        memWriteD1, memWriteD2;
    jumpT        jumpD1, jumpD2;
    logic        branchD1, branchD2;
    aluOpT       aluControlD1, aluControlD2;
    logic        aluSrcAD1, aluSrcAD2;
    logic        aluSrcBD1, aluSrcBD2;
    logic [2:0]  addressingControlD1, addressingControlD2;
    logic [2:0]  branchTypeD1, branchTypeD2;
    logic [31:0] rd1D, rd2D, rd4D, rd5D;
    logic [4:0]  rs1D, rs2D, rs4D, rs5D;
    logic [4:0]  rdD1, rdD2;
    logic [31:0] immExtD1, immExtD2;
    logic [31:0] pcPlus4D1, pcPlus4D2;
    logic [31:0] pcPlus8D1, pcPlus8D2;
    logic        en1, en2;
    logic        clearLane1, clearLane2;

    laneDecoder lane1Dec (
        .instr(instr1), .pc(pc1),
        .rs1(rs1D), .rs2(rs2D), .rd(rdD1),
        .regWrite(regWriteD1), .resultSrc(resultSrcD1), .memWrite(memWriteD1),
        .jump(jumpD1), .branch(branchD1), .aluControl(aluControlD1),
        .aluSrcA(aluSrcAD1), .aluSrcB(aluSrcBD1),
        .addressingControl(addressingControlD1), .branchType(branchTypeD1),
        .immExt(immExtD1), .pcPlus4(pcPlus4D1), .pcPlus8(pcPlus8D1)
    );

    laneDecoder lane2Dec (
        .instr(instr2), .pc(pc2),
        .rs1(rs4D), .rs2(rs5D), .rd(rdD2),
        .regWrite(regWriteD2), .resultSrc(resultSrcD2), .memWrite(memWriteD2),
        .jump(jumpD2), .branch(branchD2), .aluControl(aluControlD2),
        .aluSrcA(aluSrcAD2), .aluSrcB(aluSrcBD2),
        .addressingControl(addressingControlD2), .branchType(branchTypeD2),
        .immExt(immExtD2), .pcPlus4(pcPlus4D2), .pcPlus8(pcPlus8D2)
    );

    registerFile regFile (
        .ra1(rs1D), .ra2(rs2D), .ra4(rs4D), .ra5(rs5D),
        .rd1(rd1D), .rd2(rd2D), .rd4(rd4D), .rd5(rd5D),
        .we1(wbEn1), .wa1(wbAddr1), .wd1(wbData1),
        .we2(wbEn2), .wa2(wbAddr2), .wd2(wbData2),
        .*
    );

    issueControl issueCtrl (
        .regWrite1(regWriteD1), .rd1(rdD1),
        .rs1Lane2(rs4D), .rs2Lane2(rs5D),
        .*
    );

    decodeToExecuteRegister d2eReg (
        .pcD1(pc1), .pcD2(pc2),
        .*
    );

endmodule

// ==== bench/tbClock.sv ====
module tbClock (
    output logic clk
);

    // 40 time unit period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

endmodule

// ==== bench/decodeStageTb.sv ====
module decodeStageTb import dualIssuePkg::*; ();

    localparam int resetCycles  = 10;
    localparam int numCycles    = 2000;
    localparam int timeoutLimit = numCycles + 100;

    // weighted toward common formats, slots 9 to 15 repeat earlier opcodes
    localparam logic [6:0] opTable [16] = '{opOp, opOpImm, opLoad, opStore, opBranch, opJal,
        opJalr, opLui, opAuipc, opOp, opOpImm, opLoad, opStore, opBranch, opJal, opJalr};

    logic        clk, rst1;
    logic [31:0] instr1, pc1, instr2, pc2;
    logic        valid1, valid2, stall, flush;
    logic        wbEn1, wbEn2;
    logic [4:0]  wbAddr1, wbAddr2;
    logic [31:0] wbData1, wbData2;
    logic        regWriteE1, regWriteE2, memWriteE1, memWriteE2, branchE1, branchE2;
    resultSrcT   resultSrcE1, resultSrcE2;
    jumpT        jumpE1, jumpE2;
    aluOpT       aluControlE1, aluControlE2;
    logic        aluSrcAE1, aluSrcAE2, aluSrcBE1, aluSrcBE2;
    logic [2:0]  addressingControlE1, addressingControlE2, branchTypeE1, branchTypeE2;
    logic [31:0] rd1E, rd2E, rd4E, rd5E;
    logic [4:0]  rs1E, rs2E, rs4E, rs5E, rdE1, rdE2;
    logic [31:0] pcE1, pcE2, immExtE1, immExtE2, pcPlus4E1, pcPlus4E2, pcPlus8E1, pcPlus8E2;
    logic        splitPair;

    // model state, one entry per lane
    logic        expRegWrite[2], expMemWrite[2], expBranch[2], expSrcA[2], expSrcB[2];
    resultSrcT   expResultSrc[2];
    jumpT        expJump[2];
    aluOpT       expAlu[2];
    logic [2:0]  expAddrCtl[2], expBrType[2];
    logic [4:0]  expRsA[2], expRsB[2], expRd[2];
    logic [31:0] expOpA[2], expOpB[2], expPc[2], expImm[2], expPc4[2], expPc8[2];
    logic [31:0] modelRegs [32];
    logic [31:0] lcgState = 32'h8c17c70e;
    int ctrlErrors = 0, wordErrors = 0, indexErrors = 0, bitErrors = 0;
    int cycleCount = 0;

    tbClock clkGen (.clk(clk));

    decodeStage i_dut (.*);

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic logic writesReg(input logic [6:0] op);
        return op inside {opOp, opOpImm, opLoad, opJal, opJalr, opLui, opAuipc};
    endfunction

    function automatic aluOpT aluFor(input logic [6:0] op, input logic [2:0] f3, input logic b30);
        if (op == opBranch) return aluSub;
        if (op == opLui) return aluPassB;
        if (op != opOp && op != opOpImm) return aluAdd;
        case (f3)
            3'd0: if (op == opOp && b30) return aluSub; else return aluAdd;
            3'd1: return aluSll;
            3'd2: return aluSlt;
            3'd3: return aluSltu;
            3'd4: return aluXor;
            3'd5: if (b30) return aluSra; else return aluSrl;
            3'd6: return aluOr;
            default: return aluAnd;
        endcase
    endfunction

    function automatic logic [31:0] immFor(input logic [31:0] instr);
        logic [12:0] bOff;
        logic [20:0] jOff;
        bOff = {instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
        jOff = {instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
        case (instr[6:0])
            opLoad, opOpImm, opJalr: return 32'($signed(instr[31:20]));
            opStore: return 32'($signed({instr[31:25], instr[11:7]}));
            opBranch: return 32'($signed(bOff));
            opJal: return 32'($signed(jOff));
            opLui, opAuipc: return {instr[31:12], 12'h000};
            default: return 32'h0;
        endcase
    endfunction

    function automatic logic [31:0] readReg(input logic [4:0] a);
        return (a == 5'd0) ? 32'h0 : modelRegs[a];
    endfunction

    function automatic logic [31:0] randomInstr();
        logic [31:0] r;
        r = nextRand();
        // now and then a fully random word, mostly with an unknown opcode
        if (r[3:0] == 4'd0) return nextRand();
        return {nextRand() & 32'hffffff80} | {25'h0, opTable[r[7:4]]};
    endfunction

    task automatic clearLane(input int ln);
        expRegWrite[ln] = 1'b0;
        expMemWrite[ln] = 1'b0;
        expBranch[ln] = 1'b0;
        expSrcA[ln] = 1'b0;
        expSrcB[ln] = 1'b0;
        expResultSrc[ln] = resAlu;
        expJump[ln] = jumpNone;
        expAlu[ln] = aluAdd;
        expAddrCtl[ln] = 3'd0;
        expBrType[ln] = 3'd0;
        expRsA[ln] = 5'd0;
        expRsB[ln] = 5'd0;
        expRd[ln] = 5'd0;
        expOpA[ln] = 32'h0;
        expOpB[ln] = 32'h0;
        expPc[ln] = 32'h0;
        expImm[ln] = 32'h0;
        expPc4[ln] = 32'h0;
        expPc8[ln] = 32'h0;
    endtask

    task automatic loadLane(input int ln, input logic [31:0] instr, input logic [31:0] pc);
        logic [6:0] op;
        logic [2:0] f3;
        op = instr[6:0];
        f3 = instr[14:12];
        expRegWrite[ln] = writesReg(op);
        expMemWrite[ln] = (op == opStore);
        expBranch[ln] = (op == opBranch);
        expSrcA[ln] = (op == opJal) || (op == opAuipc);
        expSrcB[ln] = op inside {opOpImm, opLoad, opStore, opJal, opJalr, opLui, opAuipc};
        if (op == opLoad) expResultSrc[ln] = resMem;
        else if (op == opJal || op == opJalr) expResultSrc[ln] = resPcPlus4;
        else expResultSrc[ln] = resAlu;
        if (op == opJal) expJump[ln] = jumpJal;
        else if (op == opJalr) expJump[ln] = jumpJalr;
        else expJump[ln] = jumpNone;
        expAlu[ln] = aluFor(op, f3, instr[30]);
        expAddrCtl[ln] = (op == opLoad || op == opStore) ? f3 : 3'd0;
        expBrType[ln] = (op == opBranch) ? f3 : 3'd0;
        expRsA[ln] = instr[19:15];
        expRsB[ln] = instr[24:20];
        expRd[ln] = instr[11:7];
        expOpA[ln] = readReg(instr[19:15]);
        expOpB[ln] = readReg(instr[24:20]);
        expPc[ln] = pc;
        expImm[ln] = immFor(instr);
        expPc4[ln] = pc + 32'd4;
        expPc8[ln] = pc + 32'd8;
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
            bitErrors++;
        end
    endtask

    task automatic checkIndex(input string name, input logic [4:0] got, input logic [4:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
            indexErrors++;
        end
    endtask

    task automatic checkWord(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
            wordErrors++;
        end
    endtask

    task automatic checkCtrl(input string s, input aluOpT gotAlu, input aluOpT expAluOp,
                             input resultSrcT gotRes, input resultSrcT expRes,
                             input jumpT gotJump, input jumpT expJumpKind);
        if (gotAlu !== expAluOp) begin
            $display("FAILED aluControl%s: got 0x%h, expected 0x%h", s, gotAlu, expAluOp);
            ctrlErrors++;
        end
        if (gotRes !== expRes) begin
            $display("FAILED resultSrc%s: got 0x%h, expected 0x%h", s, gotRes, expRes);
            ctrlErrors++;
        end
        if (gotJump !== expJumpKind) begin
            $display("FAILED jump%s: got 0x%h, expected 0x%h", s, gotJump, expJumpKind);
            ctrlErrors++;
        end
    endtask

    task automatic checkLane(input int ln, input logic gRegWrite, input resultSrcT gRes,
                             input logic gMemWrite, input jumpT gJump, input logic gBranch,
                             input aluOpT gAlu, input logic gSrcA, input logic gSrcB,
                             input logic [2:0] gAddrCtl, input logic [2:0] gBrType,
                             input logic [31:0] gOpA, input logic [31:0] gOpB,
                             input logic [4:0] gRsA, input logic [4:0] gRsB,
                             input logic [4:0] gRd, input logic [31:0] gPc,
                             input logic [31:0] gImm, input logic [31:0] gPc4,
                             input logic [31:0] gPc8);
        string s;
        int pa;
        s = $sformatf("E%0d", ln + 1);
        // lane 2 reads through register file ports 4 and 5
        pa = (ln == 0) ? 1 : 4;
        checkCtrl(s, gAlu, expAlu[ln], gRes, expResultSrc[ln], gJump, expJump[ln]);
        checkBit({"regWrite", s}, gRegWrite, expRegWrite[ln]);
        checkBit({"memWrite", s}, gMemWrite, expMemWrite[ln]);
        checkBit({"branch", s}, gBranch, expBranch[ln]);
        checkBit({"aluSrcA", s}, gSrcA, expSrcA[ln]);
        checkBit({"aluSrcB", s}, gSrcB, expSrcB[ln]);
        checkIndex({"addressingControl", s}, {2'b00, gAddrCtl}, {2'b00, expAddrCtl[ln]});
        checkIndex({"branchType", s}, {2'b00, gBrType}, {2'b00, expBrType[ln]});
        checkIndex($sformatf("rs%0dE", pa), gRsA, expRsA[ln]);
        checkIndex($sformatf("rs%0dE", pa + 1), gRsB, expRsB[ln]);
        checkIndex({"rd", s}, gRd, expRd[ln]);
        checkWord($sformatf("rd%0dE", pa), gOpA, expOpA[ln]);
        checkWord($sformatf("rd%0dE", pa + 1), gOpB, expOpB[ln]);
        checkWord({"pc", s}, gPc, expPc[ln]);
        checkWord({"immExt", s}, gImm, expImm[ln]);
        checkWord({"pcPlus4", s}, gPc4, expPc4[ln]);
        checkWord({"pcPlus8", s}, gPc8, expPc8[ln]);
    endtask

    task automatic checkLanes();
        checkLane(0, regWriteE1, resultSrcE1, memWriteE1, jumpE1, branchE1, aluControlE1,
                  aluSrcAE1, aluSrcBE1, addressingControlE1, branchTypeE1, rd1E, rd2E,
                  rs1E, rs2E, rdE1, pcE1, immExtE1, pcPlus4E1, pcPlus8E1);
        checkLane(1, regWriteE2, resultSrcE2, memWriteE2, jumpE2, branchE2, aluControlE2,
                  aluSrcAE2, aluSrcBE2, addressingControlE2, branchTypeE2, rd4E, rd5E,
                  rs4E, rs5E, rdE2, pcE2, immExtE2, pcPlus4E2, pcPlus8E2);
    endtask

    task automatic driveRandom();
        logic [31:0] r;
        r = nextRand();
        valid1 = (r[2:0] != 3'd0);
        valid2 = (r[6:4] != 3'd0);
        stall = (r[15:8] < 8'd26);
        flush = (r[23:16] < 8'd13);
        instr1 = randomInstr();
        instr2 = randomInstr();
        // make lane 2 read lane 1's destination about a quarter of the time
        if (r[25:24] == 2'b00) instr2[19:15] = instr1[11:7];
        r = nextRand();
        pc1 = {r[31:2], 2'b00};
        pc2 = pc1 + 32'd4;
        r = nextRand();
        wbEn1 = r[0];
        wbEn2 = r[1];
        wbAddr1 = r[6:2];
        wbAddr2 = (r[9:8] == 2'b00) ? wbAddr1 : r[14:10];
        wbData1 = nextRand();
        wbData2 = nextRand();
    endtask

    // model of one rising edge, taken before the DUT's registers are looked at
    task automatic modelStep();
        logic dep;
        dep = valid1 && valid2 && writesReg(instr1[6:0]) && (instr1[11:7] != 5'd0)
              && ((instr1[11:7] == instr2[19:15]) || (instr1[11:7] == instr2[24:20]));
        checkBit("splitPair", splitPair, !flush && !stall && dep);
        if (flush) begin
            clearLane(0);
            clearLane(1);
        end else if (!stall) begin
            if (valid1) loadLane(0, instr1, pc1);
            else clearLane(0);
            if (valid2 && !dep) loadLane(1, instr2, pc2);
            else clearLane(1);
        end
        // port 2 is applied last so it wins a shared address
        if (wbEn1) modelRegs[wbAddr1] = wbData1;
        if (wbEn2) modelRegs[wbAddr2] = wbData2;
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutLimit) begin
            $display("timeout: the run did not finish within %0d cycles", timeoutLimit);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        rst1 = 1'b1;
        {instr1, pc1, instr2, pc2} = '0;
        {valid1, valid2, stall, flush, wbEn1, wbEn2} = '0;
        {wbAddr1, wbAddr2, wbData1, wbData2} = '0;
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = 32'h0;
        end
        clearLane(0);
        clearLane(1);
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        rst1 = 1'b0;
        checkLanes();
        for (int n = 0; n < numCycles; n++) begin
            driveRandom();
            @(posedge clk);
            modelStep();
            @(negedge clk);
            checkLanes();
        end
        $display("error counts: ctrl %0d, word %0d, index %0d, bit %0d",
                 ctrlErrors, wordErrors, indexErrors, bitErrors);
        if (ctrlErrors + wordErrors + indexErrors + bitErrors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== src.f ====
rtl/dualIssuePkg.sv
rtl/controlDecoder.sv
rtl/immediateGen.sv
rtl/laneDecoder.sv
rtl/registerFile.sv
rtl/issueControl.sv
rtl/decodeToExecuteRegister.sv
rtl/decodeStage.sv
bench/tbClock.sv
bench/decodeStageTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the decode stage testbench with Verilator, run it, and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module decodeStageTb -f src.f --Mdir obj_dir -o decodeStageSim \
    && ./obj_dir/decodeStageSim > sim.log 2>&1 \
    || { echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "^Simulation completed successfully$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
